/* common/iq_pkg.sv */
//####################################################################
// integer issue stage definitions
// micro-op layout, unit and operand source codes, fixed widths
//####################################################################
package iq_pkg;

  // integer physical register file
  localparam int PRF_SIZE    = 32;
  localparam int PRF_INDEX_W = 5;

  // issue lanes: 0 and 1 for alu/branch, 2 for imul/idiv
  localparam int ISSUE_WIDTH = 3;
  localparam int ALU_LANES   = 2;

  // reorder buffer tag
  localparam int TAG_W = 6;

  typedef enum logic [1:0] {
    FU_ALU  = 2'd0,
    FU_BR   = 2'd1,
    FU_IMUL = 2'd2,
    FU_IDIV = 2'd3
  } fu_code_e;

  typedef enum logic [1:0] {
    RS_FROM_RF   = 2'd0,
    RS_FROM_IMM  = 2'd1,
    RS_FROM_PC   = 2'd2,
    RS_FROM_ZERO = 2'd3
  } rs_source_e;

  typedef struct packed {
    logic                   valid;
    fu_code_e               fu_code;
    rs_source_e             rs1_source;
    logic [PRF_INDEX_W-1:0] rs1_prf_index;
    rs_source_e             rs2_source;
    logic [PRF_INDEX_W-1:0] rs2_prf_index;
    logic                   rd_valid;
    logic [PRF_INDEX_W-1:0] rd_prf_index;
    logic [TAG_W-1:0]       tag;
  } micro_op_t;

endpackage

/* common/prf_busy_if.sv */
//####################################################################
// busy lookup path between the issue queue and the busy table
//####################################################################
`timescale 1ns/1ps

interface prf_busy_if import iq_pkg::*; #(
  parameter int IQ_SIZE = 8
);

  // per slot source indices, 0 when the operand is not from the rf
  logic [IQ_SIZE-1:0][PRF_INDEX_W-1:0] rs1_index;
  logic [IQ_SIZE-1:0][PRF_INDEX_W-1:0] rs2_index;

  // per slot answers
  logic [IQ_SIZE-1:0] rs1_busy;
  logic [IQ_SIZE-1:0] rs2_busy;

  modport queue (output rs1_index, output rs2_index, input rs1_busy, input rs2_busy);

  modport busy_table (input rs1_index, input rs2_index, output rs1_busy, output rs2_busy);

endinterface

/* issue_queue/issue_slot.sv */
//####################################################################
// issue queue entry
// holds one micro-op and reports free and ready to the queue
//####################################################################
`timescale 1ns/1ps

module issue_slot import iq_pkg::*; (
  input  logic                   clock,
  input  logic                   rst,
  input  logic                   clear,
  input  logic                   load,
  input  micro_op_t              uop_in,
  input  logic                   rs1_busy,
  input  logic                   rs2_busy,
  output micro_op_t              uop,
  output logic [PRF_INDEX_W-1:0] rs1_index,
  output logic [PRF_INDEX_W-1:0] rs2_index,
  output logic                   ready,
  output logic                   free
);

  // clear on issue or flush wins over a load
  always_ff @(posedge clock) begin
    if (rst || clear) begin
      uop.valid <= 1'b0;
    end else if (load && uop_in.valid) begin
      uop <= uop_in;
    end
  end

  // non-rf operands look up register 0, which is never busy
  assign rs1_index = (uop.rs1_source == RS_FROM_RF) ? uop.rs1_prf_index : '0;
  assign rs2_index = (uop.rs2_source == RS_FROM_RF) ? uop.rs2_prf_index : '0;

  assign ready = uop.valid && !rs1_busy && !rs2_busy;
  assign free  = !uop.valid;

endmodule

/* issue_queue/issue_select.sv */
//####################################################################
// lowest-index priority picker with several grants
// grant i takes the lowest request bit left over by grants 0..i-1
//####################################################################
`timescale 1ns/1ps

module issue_select #(
  parameter int REQS  = 2,
  parameter int WIDTH = 8,
  localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic [WIDTH-1:0]           request,
  output logic [REQS-1:0][IDX_W-1:0] sel,
  output logic [REQS-1:0]            sel_valid
);

  // requests not yet granted
  logic [WIDTH-1:0] remaining;

  always_comb begin
    remaining = request;
    sel       = '0;
    sel_valid = '0;
    for (int i = 0; i < REQS; i++) begin
      // first set bit from the bottom
      for (int j = 0; j < WIDTH; j++) begin
        if (remaining[j] && !sel_valid[i]) begin
          sel[i]       = IDX_W'(j);
          sel_valid[i] = 1'b1;
        end
      end
      if (sel_valid[i]) begin
        remaining[sel[i]] = 1'b0;
      end
    end
  end

endmodule

/* issue_queue/issue_queue.sv */
//####################################################################
// integer issue queue
// dispatch into lowest free slots, oldest-position pick per lane,
// free count tracking and full flag
//####################################################################
`timescale 1ns/1ps

module issue_queue import iq_pkg::*; #(
  parameter int IQ_SIZE        = 8,
  parameter int DISPATCH_WIDTH = 2
) (
  input  logic                                clock,
  input  logic                                rst,
  input  logic                                flush,
  input  micro_op_t [DISPATCH_WIDTH-1:0]      uop_in,
  output micro_op_t [ISSUE_WIDTH-1:0]         uop_out,
  output logic                                full,
  prf_busy_if.queue                           busy
);

  localparam int IDX_W     = $clog2(IQ_SIZE);
  localparam int CNT_W     = $clog2(IQ_SIZE) + 1;
  localparam int MUL_LANES = ISSUE_WIDTH - ALU_LANES;

  micro_op_t [IQ_SIZE-1:0] slot_uop;
  micro_op_t [IQ_SIZE-1:0] slot_uop_in;
  logic      [IQ_SIZE-1:0] slot_ready;
  logic      [IQ_SIZE-1:0] slot_free;
  logic      [IQ_SIZE-1:0] ready_alu;
  logic      [IQ_SIZE-1:0] ready_mul;
  logic      [IQ_SIZE-1:0] load;
  logic      [IQ_SIZE-1:0] issue_clear;
  logic      [IQ_SIZE-1:0] slot_clear;

  logic [DISPATCH_WIDTH-1:0][IDX_W-1:0] alloc_sel;
  logic [DISPATCH_WIDTH-1:0]            alloc_valid;
  logic [ALU_LANES-1:0][IDX_W-1:0]      alu_sel;
  logic [ALU_LANES-1:0]                 alu_valid;
  logic [MUL_LANES-1:0][IDX_W-1:0]      mul_sel;
  logic [MUL_LANES-1:0]                 mul_valid;

  logic [CNT_W-1:0] in_count;
  logic [CNT_W-1:0] out_count;
  logic [CNT_W-1:0] free_count;
  logic [CNT_W-1:0] free_count_q;

  // a slot empties on its own issue or on a flush
  assign slot_clear = issue_clear | {IQ_SIZE{flush}};

  for (genvar k = 0; k < IQ_SIZE; k++) begin : g_slot
    issue_slot i_issue_slot (
      .clock     (clock),
      .rst       (rst),
      .clear     (slot_clear[k]),
      .load      (load[k]),
      .uop_in    (slot_uop_in[k]),
      .rs1_busy  (busy.rs1_busy[k]),
      .rs2_busy  (busy.rs2_busy[k]),
      .uop       (slot_uop[k]),
      .rs1_index (busy.rs1_index[k]),
      .rs2_index (busy.rs2_index[k]),
      .ready     (slot_ready[k]),
      .free      (slot_free[k])
    );

    // split ready slots by lane class
    assign ready_alu[k] = slot_ready[k] &&
                          (slot_uop[k].fu_code == FU_ALU || slot_uop[k].fu_code == FU_BR);
    assign ready_mul[k] = slot_ready[k] &&
                          (slot_uop[k].fu_code == FU_IMUL || slot_uop[k].fu_code == FU_IDIV);
  end

  issue_select #(.REQS(DISPATCH_WIDTH), .WIDTH(IQ_SIZE)) i_alloc_select (
    .request   (slot_free),
    .sel       (alloc_sel),
    .sel_valid (alloc_valid)
  );

  issue_select #(.REQS(ALU_LANES), .WIDTH(IQ_SIZE)) i_alu_select (
    .request   (ready_alu),
    .sel       (alu_sel),
    .sel_valid (alu_valid)
  );

  issue_select #(.REQS(MUL_LANES), .WIDTH(IQ_SIZE)) i_mul_select (
    .request   (ready_mul),
    .sel       (mul_sel),
    .sel_valid (mul_valid)
  );

  // dispatch lane i goes to the i-th free slot
  always_comb begin
    load        = '0;
    slot_uop_in = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      if (alloc_valid[i] && uop_in[i].valid) begin
        load[alloc_sel[i]]        = 1'b1;
        slot_uop_in[alloc_sel[i]] = uop_in[i];
      end
    end
  end

  // lanes 0..ALU_LANES-1 from alu/br picks, the rest from imul/idiv
  always_comb begin
    uop_out     = '0;
    issue_clear = '0;
    for (int l = 0; l < ALU_LANES; l++) begin
      if (alu_valid[l]) begin
        uop_out[l]           = slot_uop[alu_sel[l]];
        issue_clear[alu_sel[l]] = 1'b1;
      end
    end
    for (int m = 0; m < MUL_LANES; m++) begin
      if (mul_valid[m]) begin
        uop_out[ALU_LANES+m]    = slot_uop[mul_sel[m]];
        issue_clear[mul_sel[m]] = 1'b1;
      end
    end
  end

  always_comb begin
    in_count = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      if (uop_in[i].valid) begin
        in_count = in_count + 1'b1;
      end
    end
  end

  always_comb begin
    out_count = '0;
    for (int k = 0; k < IQ_SIZE; k++) begin
      if (issue_clear[k]) begin
        out_count = out_count + 1'b1;
      end
    end
  end

  // free slots once this cycle's moves land
  assign free_count = free_count_q - in_count + out_count;
  assign full       = free_count < CNT_W'(DISPATCH_WIDTH);

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      free_count_q <= CNT_W'(IQ_SIZE);
    end else begin
      free_count_q <= free_count;
    end
  end

  // dispatch must not overrun the slots that were free at the last edge
  a_no_overfill : assert property (
    @(posedge clock) disable iff (rst || flush) in_count <= free_count_q
  ) else $error("dispatch of %0d micro-ops with %0d free slots", in_count, free_count_q);

  // no dispatch lands in a slot that issue or flush empties at this edge
  a_load_clear_disjoint : assert property (
    @(posedge clock) disable iff (rst) (load & slot_clear) == '0
  ) else $error("slot loaded and cleared in one cycle: %b", load & slot_clear);

endmodule

/* verilog/prf_busy_table.sv */
//####################################################################
// integer physical register busy table
// set by dispatched destinations, cleared by writeback and flush
//####################################################################
`timescale 1ns/1ps

module prf_busy_table import iq_pkg::*; #(
  parameter int IQ_SIZE        = 8,
  parameter int DISPATCH_WIDTH = 2,
  parameter int WB_WIDTH       = 2
) (
  input  logic                                clock,
  input  logic                                rst,
  input  logic                                flush,
  input  micro_op_t [DISPATCH_WIDTH-1:0]      alloc_uop,
  input  logic [WB_WIDTH-1:0]                 wb_valid,
  input  logic [WB_WIDTH-1:0][PRF_INDEX_W-1:0] wb_index,
  prf_busy_if.busy_table                      busy
);

  logic [PRF_SIZE-1:0] busy_q;
  logic [PRF_SIZE-1:0] busy_next;

  // clears first so a set in the same cycle wins
  always_comb begin
    busy_next = busy_q;
    for (int w = 0; w < WB_WIDTH; w++) begin
      if (wb_valid[w]) begin
        busy_next[wb_index[w]] = 1'b0;
      end
    end
    for (int d = 0; d < DISPATCH_WIDTH; d++) begin
      if (alloc_uop[d].valid && alloc_uop[d].rd_valid) begin
        busy_next[alloc_uop[d].rd_prf_index] = 1'b1;
      end
    end
    // x0 is hardwired
    busy_next[0] = 1'b0;
  end

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_next;
    end
  end

  // two lookups per slot against the registered bits
  always_comb begin
    for (int k = 0; k < IQ_SIZE; k++) begin
      busy.rs1_busy[k] = busy_q[busy.rs1_index[k]];
      busy.rs2_busy[k] = busy_q[busy.rs2_index[k]];
    end
  end

  for (genvar w = 0; w < WB_WIDTH; w++) begin : g_wb_check
    // execution side never writes back to x0
    a_wb_not_x0 : assert property (
      @(posedge clock) disable iff (rst) wb_valid[w] |-> wb_index[w] != '0
    ) else $error("writeback port %0d targets register 0", w);
  end

endmodule

/* verilog/int_issue_unit.sv */
//####################################################################
// integer issue unit
// issue queue plus physical register busy table
//####################################################################
`timescale 1ns/1ps

module int_issue_unit import iq_pkg::*; #(
  parameter int IQ_SIZE        = 8,
  parameter int DISPATCH_WIDTH = 2,
  parameter int WB_WIDTH       = 2
) (
  input  logic                                 clock,
  input  logic                                 rst,
  input  logic                                 flush,
  input  micro_op_t [DISPATCH_WIDTH-1:0]       dispatch_uop,
  input  logic [WB_WIDTH-1:0]                  wb_valid,
  input  logic [WB_WIDTH-1:0][PRF_INDEX_W-1:0] wb_index,
  output micro_op_t [ISSUE_WIDTH-1:0]          issue_uop,
  output logic                                 iq_full
);

  // slot sources out, busy answers back
  prf_busy_if #(.IQ_SIZE(IQ_SIZE)) busy_if ();

  issue_queue #(
    .IQ_SIZE        (IQ_SIZE),
    .DISPATCH_WIDTH (DISPATCH_WIDTH)
  ) i_issue_queue (
    .clock   (clock),
    .rst     (rst),
    .flush   (flush),
    .uop_in  (dispatch_uop),
    .uop_out (issue_uop),
    .full    (iq_full),
    .busy    (busy_if.queue)
  );

  // dispatched destinations are marked busy here
  prf_busy_table #(
    .IQ_SIZE        (IQ_SIZE),
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .WB_WIDTH       (WB_WIDTH)
  ) i_prf_busy_table (
    .clock     (clock),
    .rst       (rst),
    .flush     (flush),
    .alloc_uop (dispatch_uop),
    .wb_valid  (wb_valid),
    .wb_index  (wb_index),
    .busy      (busy_if.busy_table)
  );

endmodule

/* verification/tb_clock_gen.sv */
//####################################################################
// testbench clock and power-on reset
//####################################################################
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 5
) (
  output logic clock,
  output logic rst
);

  initial begin
    clock = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clock = ~clock;
    end
  end

  // released on a rising edge like any other driven input
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    rst <= 1'b0;
  end

endmodule

/* verification/iq_checker.sv */
//####################################################################
// issue unit checker
// compares issue lanes and the full flag with the trace each cycle,
// counts checks and errors, watches the cycle limit
//####################################################################
`timescale 1ns/1ps

module iq_checker import iq_pkg::*; (
  input  logic                              clock,
  input  micro_op_t [ISSUE_WIDTH-1:0]       issue_uop,
  input  logic                              iq_full,
  input  logic                              check_en,
  input  logic [ISSUE_WIDTH-1:0]            exp_valid,
  input  logic [ISSUE_WIDTH-1:0][TAG_W-1:0] exp_tag,
  input  logic                              exp_full,
  input  logic                              run_done,
  input  int                                cycle_limit,
  output int                                error_count,
  output int                                check_count,
  output logic                              timed_out
);

  int cycle_count;

  initial begin
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    timed_out   = 1'b0;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, got);
    end
  endtask

  // outputs settle between edges, so look at them on the falling edge
  always @(negedge clock) begin
    if (check_en) begin
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        compare_value($sformatf("issue_uop[%0d].valid", l),
                      32'(issue_uop[l].valid), 32'(exp_valid[l]));
        // tag only means something on a valid lane
        if (exp_valid[l]) begin
          compare_value($sformatf("issue_uop[%0d].tag", l),
                        32'(issue_uop[l].tag), 32'(exp_tag[l]));
        end
      end
      compare_value("iq_full", 32'(iq_full), 32'(exp_full));
    end
  end

  // cycle limit includes the reset cycles
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (!run_done && !timed_out && cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      timed_out <= 1'b1;
    end
  end

endmodule

/* verification/tb_int_issue_unit.sv */
//####################################################################
// integer issue unit testbench
// replays the cycle trace into the DUT, checker compares outputs
//####################################################################
`timescale 1ns/1ps

module tb_int_issue_unit import iq_pkg::*; ();

  localparam int IQ_SIZE        = 8;
  localparam int DISPATCH_WIDTH = 2;
  localparam int WB_WIDTH       = 2;
  localparam int RESET_CYCLES   = 5;
  localparam int FIELDS         = 30;
  localparam int MAX_LINES      = 64;
  localparam string TRACE_FILE  = "verification/int_issue_trace.txt";

  logic clock;
  logic rst;
  logic flush;
  micro_op_t [DISPATCH_WIDTH-1:0]       dispatch_uop;
  logic [WB_WIDTH-1:0]                  wb_valid;
  logic [WB_WIDTH-1:0][PRF_INDEX_W-1:0] wb_index;
  micro_op_t [ISSUE_WIDTH-1:0]          issue_uop;
  logic                                 iq_full;

  logic                              check_en;
  logic [ISSUE_WIDTH-1:0]            exp_valid;
  logic [ISSUE_WIDTH-1:0][TAG_W-1:0] exp_tag;
  logic                              exp_full;
  logic                              run_done;
  logic                              timed_out;
  logic                              trace_error;
  int                                cycle_limit;
  int                                trace_len;
  int                                error_count;
  int                                check_count;

  logic [7:0] trace_mem [MAX_LINES*FIELDS];

  tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(RESET_CYCLES)) i_clock_gen (
    .clock (clock),
    .rst   (rst)
  );

  int_issue_unit #(
    .IQ_SIZE        (IQ_SIZE),
    .DISPATCH_WIDTH (DISPATCH_WIDTH),
    .WB_WIDTH       (WB_WIDTH)
  ) i_int_issue_unit (
    .clock        (clock),
    .rst          (rst),
    .flush        (flush),
    .dispatch_uop (dispatch_uop),
    .wb_valid     (wb_valid),
    .wb_index     (wb_index),
    .issue_uop    (issue_uop),
    .iq_full      (iq_full)
  );

  iq_checker i_iq_checker (
    .clock       (clock),
    .issue_uop   (issue_uop),
    .iq_full     (iq_full),
    .check_en    (check_en),
    .exp_valid   (exp_valid),
    .exp_tag     (exp_tag),
    .exp_full    (exp_full),
    .run_done    (run_done),
    .cycle_limit (cycle_limit),
    .error_count (error_count),
    .check_count (check_count),
    .timed_out   (timed_out)
  );

  // nine trace fields starting at address at
  function automatic micro_op_t uop_fields(input int at);
    micro_op_t u;
    u.valid         = trace_mem[at][0];
    u.fu_code       = fu_code_e'(trace_mem[at+1][1:0]);
    u.rs1_source    = rs_source_e'(trace_mem[at+2][1:0]);
    u.rs1_prf_index = trace_mem[at+3][PRF_INDEX_W-1:0];
    u.rs2_source    = rs_source_e'(trace_mem[at+4][1:0]);
    u.rs2_prf_index = trace_mem[at+5][PRF_INDEX_W-1:0];
    u.rd_valid      = trace_mem[at+6][0];
    u.rd_prf_index  = trace_mem[at+7][PRF_INDEX_W-1:0];
    u.tag           = trace_mem[at+8][TAG_W-1:0];
    return u;
  endfunction

  // unused entries carry bit 7, which no flush field has, so it marks the end
  task automatic load_trace();
    for (int a = 0; a < MAX_LINES * FIELDS; a++) begin
      trace_mem[a] = 8'h80 | 8'(a ^ (a >> 7));
    end
    $readmemh(TRACE_FILE, trace_mem);
    trace_len = 0;
    while (trace_len < MAX_LINES && !trace_mem[trace_len*FIELDS][7]) begin
      trace_len++;
    end
  endtask

  task automatic drive_line(input int n);
    int base;
    base = n * FIELDS;
    flush           <= trace_mem[base][0];
    dispatch_uop[0] <= uop_fields(base + 1);
    dispatch_uop[1] <= uop_fields(base + 10);
    wb_valid[0]     <= trace_mem[base+19][0];
    wb_index[0]     <= trace_mem[base+20][PRF_INDEX_W-1:0];
    wb_valid[1]     <= trace_mem[base+21][0];
    wb_index[1]     <= trace_mem[base+22][PRF_INDEX_W-1:0];
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      exp_valid[l] <= trace_mem[base+23+2*l][0];
      exp_tag[l]   <= trace_mem[base+24+2*l][TAG_W-1:0];
    end
    exp_full <= trace_mem[base+29][0];
    check_en <= 1'b1;
  endtask

  initial begin
    flush        = 1'b0;
    dispatch_uop = '0;
    wb_valid     = '0;
    wb_index     = '0;
    check_en     = 1'b0;
    exp_valid    = '0;
    exp_tag      = '0;
    exp_full     = 1'b0;
    run_done     = 1'b0;
    trace_error  = 1'b0;
    load_trace();
    cycle_limit = trace_len + RESET_CYCLES + 20;
    if (trace_len == 0) begin
      $display("trace %s could not be read or holds no cycles", TRACE_FILE);
      trace_error = 1'b1;
    end
    @(posedge clock);
    while (rst) begin
      @(posedge clock);
    end
    for (int n = 0; n < trace_len; n++) begin
      drive_line(n);
      @(posedge clock);
    end
    flush        <= 1'b0;
    dispatch_uop <= '0;
    wb_valid     <= '0;
    check_en     <= 1'b0;
    run_done     <= 1'b1;
  end

  initial begin
    wait (run_done || timed_out);
    @(negedge clock);
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0 && !timed_out && !trace_error) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* verification/int_issue_trace.txt */
// flush | dispatch 0: v fu s1 rs1 s2 rs2 rdv rd tag | dispatch 1: same | wb0 v idx wb1 v idx
// | expected lane 0, 1, 2 as valid tag | expected iq_full
// fu 0 alu 1 br 2 imul 3 idiv; source 0 rf 1 imm 2 pc 3 zero; all values hex
// after reset, then two independent alu ops issue together
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  0 00 0 00 0 00 0
0  1 0 1 00 3 00 1 01 01  1 0 0 00 1 00 1 02 02  0 00 0 00  0 00 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  1 01 1 02 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  1 01 1 02  0 00 0 00 0 00 0
// dependency on x3, pc source with a busy index does not block
0  1 0 1 00 1 00 1 03 03  1 0 0 03 0 00 1 04 04  0 00 0 00  0 00 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  1 03 0 00 0 00 0
0  1 0 0 00 2 03 1 05 05  0 0 0 00 0 00 0 00 00  0 00 0 00  0 00 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  1 03 0 00  1 05 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  1 04 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  1 04 1 05  0 00 0 00 0 00 0
// three alu/br and one imul wait on x7
0  1 0 1 00 1 00 1 07 10  1 0 0 07 1 00 1 08 11  0 00 0 00  0 00 0 00 0 00 0
0  1 1 0 07 0 00 0 00 12  1 0 1 00 0 07 1 09 13  0 00 0 00  1 10 0 00 0 00 0
0  1 2 0 07 0 00 1 0a 14  0 0 0 00 0 00 0 00 00  0 00 0 00  0 00 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  1 07 0 00  0 00 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  1 11 1 12 1 14 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  1 13 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  1 08 1 09  0 00 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  1 0a 0 00  0 00 0 00 0 00 0
// fill with ops blocked on x0b until fewer than two slots remain
0  1 0 1 00 1 00 1 0b 20  1 0 0 0b 1 00 1 0c 21  0 00 0 00  0 00 0 00 0 00 0
0  1 0 0 0b 1 00 0 00 22  1 3 0 0b 0 0b 1 0d 23  0 00 0 00  1 20 0 00 0 00 0
0  1 0 0 0b 0 00 0 00 24  1 1 1 00 0 0b 0 00 25  0 00 0 00  0 00 0 00 0 00 0
0  1 0 0 0b 1 00 0 00 26  1 2 0 0b 1 00 0 00 27  0 00 0 00  0 00 0 00 0 00 1
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  1 0b 0 00  0 00 0 00 0 00 1
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  1 24 1 21 1 23 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  1 22 1 25 1 27 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  1 26 0 00 0 00 0
// flush drops blocked ops and clears busy bits
0  1 0 0 0c 1 00 1 0e 30  1 2 0 0d 1 00 1 0f 31  0 00 0 00  0 00 0 00 0 00 0
1  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  0 00 0 00 0 00 0
0  1 0 0 0c 0 0d 1 11 32  1 3 0 0e 1 00 1 12 33  0 00 0 00  0 00 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  1 32 0 00 1 33 0
// set of x11 beats its writeback in the same cycle
0  1 0 1 00 1 00 1 11 34  1 0 0 11 1 00 0 00 35  1 11 1 12  0 00 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  1 34 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  1 11 0 00  0 00 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  1 35 0 00 0 00 0
0  0 0 0 00 0 00 0 00 00  0 0 0 00 0 00 0 00 00  0 00 0 00  0 00 0 00 0 00 0

/* int_issue_unit.f */
common/iq_pkg.sv
common/prf_busy_if.sv
issue_queue/issue_slot.sv
issue_queue/issue_select.sv
issue_queue/issue_queue.sv
verilog/prf_busy_table.sv
verilog/int_issue_unit.sv
verification/tb_clock_gen.sv
verification/iq_checker.sv
verification/tb_int_issue_unit.sv

/* Makefile */
SIM        = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_int_issue_unit
FILELIST   = int_issue_unit.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = ** PASS **
FAIL_MSG   = ** FAIL **

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
